/* logic/lsu.sv */
`timescale 1ns/1ps

module lsu (
	input  logic               clock,
	input  logic               reset,

	input  lsu_pkg::lsu_req_t  req,
	input  logic               req_valid,
	output logic               req_ready,
	output lsu_pkg::lsu_req_t  req_q, // held request, feeds the aligner

	output mem_pkg::ar_chan_t  ar,
	output logic               ar_valid,
	input  logic               ar_ready,
	input  mem_pkg::r_chan_t   r,
	input  logic               r_valid,
	output logic               r_ready,

	output mem_pkg::aw_chan_t  aw,
	output logic               aw_valid,
	input  logic               aw_ready,
	output logic               w_valid,
	input  logic               w_ready,
	input  logic               b_valid,
	output logic               b_ready,

	input  mem_pkg::data_t     load_val,

	output lsu_pkg::lsu_wb_t   wb,
	output logic               wb_valid
);

	lsu_pkg::lsu_state_t state;
	logic                accept;
	mem_pkg::data_t      snpc;
	mem_pkg::data_t      alu_val;

	assign req_ready = (state == lsu_pkg::st_idle);
	assign accept    = req_valid & req_ready;
	assign wb_valid  = (state == lsu_pkg::st_done); // one cycle, then idle

	assign r_ready = 1'b1;
	assign b_ready = 1'b1;

	// bus address and size come from the held request
	assign ar = '{addr: req_q.exu_val, size: {1'b0, req_q.width[1:0]}};
	assign aw = '{addr: req_q.exu_val, size: {1'b0, req_q.width[1:0]}};

	assign snpc = req.pc + 32'd4;

	always_comb begin
		case (req.wb_src)
			lsu_pkg::src_snpc: alu_val = snpc;
			lsu_pkg::src_csr:  alu_val = req.csr_val;
			default:           alu_val = req.exu_val;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= lsu_pkg::st_idle;
			ar_valid <= 1'b0;
			aw_valid <= 1'b0;
			w_valid  <= 1'b0;
		end else begin
			case (state)
				lsu_pkg::st_idle: begin
					if (accept) begin
						case (req.op)
							lsu_pkg::op_load: begin
								state    <= lsu_pkg::st_read;
								ar_valid <= 1'b1;
							end
							lsu_pkg::op_store: begin
								state    <= lsu_pkg::st_write;
								aw_valid <= 1'b1;
								w_valid  <= 1'b1;
							end
							default: state <= lsu_pkg::st_done;
						endcase
					end
				end
				lsu_pkg::st_read: begin
					if (ar_valid && ar_ready)
						ar_valid <= 1'b0;
					if (r_valid && r_ready)
						state <= lsu_pkg::st_done;
				end
				lsu_pkg::st_write: begin
					// aw and w may finish on different edges
					if (aw_valid && aw_ready)
						aw_valid <= 1'b0;
					if (w_valid && w_ready)
						w_valid <= 1'b0;
					if (b_valid && b_ready)
						state <= lsu_pkg::st_done;
				end
				default: begin
					state <= lsu_pkg::st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			req_q      <= req;
			wb.wb_val  <= alu_val;
			wb.rd      <= req.rd;
			wb.reg_wen <= req.reg_wen;
			wb.pc      <= req.pc;
		end else if (state == lsu_pkg::st_read && r_valid && r_ready) begin
			wb.wb_val <= load_val; // aligned and extended read data
		end
	end

endmodule

/* logic/lsu_align.sv */
`timescale 1ns/1ps

module lsu_align (
	input  lsu_pkg::mem_width_t width,
	input  logic [1:0]          addr_low,
	input  mem_pkg::data_t      store_data,
	input  mem_pkg::strb_t      store_mask,
	input  mem_pkg::data_t      rdata,
	output mem_pkg::data_t      wdata,
	output mem_pkg::strb_t      wstrb,
	output mem_pkg::data_t      load_val
);

	logic [4:0]     bit_shift;
	mem_pkg::data_t rdata_shift;

	assign bit_shift = {addr_low, 3'b000}; // byte offset in bits

	// store side, move data and lanes up to the addressed byte
	assign wdata = store_data << bit_shift;
	assign wstrb = store_mask << addr_low;

	// load side, bring the addressed byte down to lane 0
	assign rdata_shift = rdata >> bit_shift;

	always_comb begin
		case (width)
			lsu_pkg::width_b: begin
				load_val = {{24{rdata_shift[7]}}, rdata_shift[7:0]};
			end
			lsu_pkg::width_h: begin
				load_val = {{16{rdata_shift[15]}}, rdata_shift[15:0]};
			end
			lsu_pkg::width_w: begin
				load_val = rdata_shift;
			end
			lsu_pkg::width_bu: begin
				load_val = {24'h0, rdata_shift[7:0]};
			end
			lsu_pkg::width_hu: begin
				load_val = {16'h0, rdata_shift[15:0]};
			end
			default: begin
				load_val = '0; // not a load encoding
			end
		endcase
	end

endmodule

/* logic/lsu_pkg.sv */
package lsu_pkg;

	// load/store width, same encoding as funct3
	typedef enum logic [2:0] {
		width_b  = 3'b000,
		width_h  = 3'b001,
		width_w  = 3'b010,
		width_bu = 3'b100,
		width_hu = 3'b101
	} mem_width_t;

	// where a non-memory result comes from
	typedef enum logic [1:0] {
		src_exu  = 2'b00,
		src_snpc = 2'b01, // jumps write pc+4
		src_csr  = 2'b10
	} wb_src_t;

	typedef enum logic [1:0] {
		op_alu   = 2'b00,
		op_load  = 2'b01,
		op_store = 2'b10
	} lsu_op_t;

	typedef enum logic [1:0] {
		st_idle  = 2'b00,
		st_read  = 2'b01,
		st_write = 2'b10,
		st_done  = 2'b11
	} lsu_state_t;

	typedef struct packed {
		lsu_op_t       op;
		mem_width_t    width;
		wb_src_t       wb_src;
		mem_pkg::data_t exu_val; // alu result or memory address
		mem_pkg::data_t csr_val;
		mem_pkg::data_t store_data;
		mem_pkg::strb_t store_mask;
		logic [3:0]    rd;
		logic          reg_wen;
		mem_pkg::addr_t pc;
	} lsu_req_t;

	typedef struct packed {
		mem_pkg::data_t wb_val;
		logic [3:0]    rd;
		logic          reg_wen;
		mem_pkg::addr_t pc;
	} lsu_wb_t;

endpackage

/* logic/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top (
	input  logic              clock,
	input  logic              reset,
	input  lsu_pkg::lsu_req_t req,
	input  logic              req_valid,
	output logic              req_ready,
	output lsu_pkg::lsu_wb_t  wb,
	output logic              wb_valid
);

	lsu_pkg::lsu_req_t req_q;
	mem_pkg::ar_chan_t ar;
	mem_pkg::r_chan_t  r;
	mem_pkg::aw_chan_t aw;
	mem_pkg::w_chan_t  w;
	logic              ar_valid, ar_ready, r_valid, r_ready;
	logic              aw_valid, aw_ready, w_valid, w_ready;
	logic              b_valid, b_ready;
	mem_pkg::data_t    wdata;
	mem_pkg::strb_t    wstrb;
	mem_pkg::data_t    load_val;

	assign w = '{data: wdata, strb: wstrb};

	lsu i_lsu (
		.clock(clock), .reset(reset),
		.req(req), .req_valid(req_valid), .req_ready(req_ready), .req_q(req_q),
		.ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r(r), .r_valid(r_valid), .r_ready(r_ready),
		.aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
		.w_valid(w_valid), .w_ready(w_ready),
		.b_valid(b_valid), .b_ready(b_ready),
		.load_val(load_val),
		.wb(wb), .wb_valid(wb_valid)
	);

	lsu_align i_align (
		.width(req_q.width), .addr_low(req_q.exu_val[1:0]),
		.store_data(req_q.store_data), .store_mask(req_q.store_mask),
		.rdata(r.data),
		.wdata(wdata), .wstrb(wstrb), .load_val(load_val)
	);

	sram_axi i_sram (
		.clock(clock), .reset(reset),
		.ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r(r), .r_valid(r_valid), .r_ready(r_ready),
		.aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
		.w(w), .w_valid(w_valid), .w_ready(w_ready),
		.b_resp(), .b_valid(b_valid), .b_ready(b_ready)
	);

endmodule

/* logic/mem_pkg.sv */
package mem_pkg;

	localparam int mem_words      = 256; // 32-bit words in the sram
	localparam int mem_index_bits = $clog2(mem_words);
	localparam int mem_latency    = 2; // handshake to rvalid/bvalid
	localparam int lat_bits       = $clog2(mem_latency + 1);

	localparam logic [1:0] resp_okay = 2'b00;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0]  strb_t;

	// read address channel
	typedef struct packed {
		addr_t      addr;
		logic [2:0] size; // log2 of bytes
	} ar_chan_t;

	// write address channel
	typedef struct packed {
		addr_t      addr;
		logic [2:0] size;
	} aw_chan_t;

	typedef struct packed {
		data_t data;
		strb_t strb; // one bit per byte lane
	} w_chan_t;

	typedef struct packed {
		data_t      data;
		logic [1:0] resp;
	} r_chan_t;

endpackage

/* logic/sram_axi.sv */
`timescale 1ns/1ps

module sram_axi (
	input  logic              clock,
	input  logic              reset,

	input  mem_pkg::ar_chan_t ar,
	input  logic              ar_valid,
	output logic              ar_ready,
	output mem_pkg::r_chan_t  r,
	output logic              r_valid,
	input  logic              r_ready,

	input  mem_pkg::aw_chan_t aw,
	input  logic              aw_valid,
	output logic              aw_ready,
	input  mem_pkg::w_chan_t  w,
	input  logic              w_valid,
	output logic              w_ready,
	output logic [1:0]        b_resp,
	output logic              b_valid,
	input  logic              b_ready
);

	typedef enum logic [2:0] {
		sr_clear,
		sr_idle,
		sr_read_wait,
		sr_write_wait,
		sr_read_resp,
		sr_write_resp
	} sram_state_t;

	mem_pkg::data_t                      mem [mem_pkg::mem_words];
	sram_state_t                         state;
	logic [mem_pkg::mem_index_bits-1:0]  clr_idx;
	logic [mem_pkg::mem_index_bits-1:0]  rd_idx;
	logic [mem_pkg::mem_index_bits-1:0]  wr_idx;
	logic [mem_pkg::lat_bits-1:0]        cnt;
	mem_pkg::data_t                      rdata_q;

	assign ar_ready = (state == sr_idle);
	// aw and w are taken together, reads win a tie
	assign aw_ready = (state == sr_idle) & aw_valid & w_valid & ~ar_valid;
	assign w_ready  = aw_ready;

	assign r_valid = (state == sr_read_resp);
	assign b_valid = (state == sr_write_resp);
	assign r       = '{data: rdata_q, resp: mem_pkg::resp_okay};
	assign b_resp  = mem_pkg::resp_okay;

	// word index, address wraps at mem_words
	assign wr_idx = aw.addr[2 +: mem_pkg::mem_index_bits];

	always_ff @(posedge clock) begin
		if (reset) begin
			state   <= sr_clear;
			clr_idx <= '0;
			cnt     <= '0;
		end else begin
			case (state)
				sr_clear: begin
					clr_idx <= clr_idx + 1'b1;
					if (clr_idx == mem_pkg::mem_index_bits'(mem_pkg::mem_words - 1))
						state <= sr_idle;
				end
				sr_idle: begin
					if (ar_valid && ar_ready) begin
						state <= sr_read_wait;
						cnt   <= mem_pkg::lat_bits'(mem_pkg::mem_latency - 1);
					end else if (aw_valid && aw_ready) begin
						state <= sr_write_wait;
						cnt   <= mem_pkg::lat_bits'(mem_pkg::mem_latency - 1);
					end
				end
				sr_read_wait: begin
					if (cnt == '0)
						state <= sr_read_resp;
					else
						cnt <= cnt - 1'b1;
				end
				sr_write_wait: begin
					if (cnt == '0)
						state <= sr_write_resp;
					else
						cnt <= cnt - 1'b1;
				end
				sr_read_resp: begin
					if (r_ready)
						state <= sr_idle;
				end
				default: begin
					if (b_ready)
						state <= sr_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == sr_clear) begin
			mem[clr_idx] <= '0;
		end else if (aw_valid && aw_ready) begin
			for (int i = 0; i < 4; i++) begin
				if (w.strb[i])
					mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
			end
		end
		if (ar_valid && ar_ready)
			rd_idx <= ar.addr[2 +: mem_pkg::mem_index_bits];
		if (state == sr_read_wait && cnt == '0)
			rdata_q <= mem[rd_idx]; // whole word, lsu picks lanes
	end

endmodule

/* lsu_subsystem.f */
logic/mem_pkg.sv
logic/lsu_pkg.sv
logic/lsu_align.sv
logic/lsu.sv
logic/sram_axi.sv
logic/lsu_top.sv
tb/lsu_tb.sv

/* tb/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;

	localparam int num_entries    = 25;
	localparam int reset_cycles   = 16;
	localparam int mem_bytes      = mem_pkg::mem_words * 4;
	// sram clears every word after reset before it takes any request
	localparam int timeout_cycles = reset_cycles + mem_pkg::mem_words + num_entries * 20;

	typedef struct packed {
		lsu_pkg::lsu_req_t req;
		mem_pkg::data_t    exp_val; // expected wb_val
	} vector_t;

	logic              clock = 1'b0;
	logic              reset;
	lsu_pkg::lsu_req_t req;
	logic              req_valid;
	logic              req_ready;
	lsu_pkg::lsu_wb_t  wb;
	logic              wb_valid;

	vector_t    vectors [num_entries];
	logic [7:0] model_mem [mem_bytes]; // byte image of the sram
	int         errors       = 0;
	int         accept_count = 0;
	int         wb_count     = 0;
	logic       busy         = 1'b0;

	always #5 clock = ~clock;

	lsu_top i_dut (
		.clock(clock), .reset(reset),
		.req(req), .req_valid(req_valid), .req_ready(req_ready),
		.wb(wb), .wb_valid(wb_valid)
	);

	function automatic vector_t make_vector(
		lsu_pkg::lsu_op_t op, lsu_pkg::mem_width_t width, lsu_pkg::wb_src_t src,
		mem_pkg::data_t exu_val, mem_pkg::data_t csr_val, mem_pkg::addr_t pc,
		mem_pkg::data_t store_data, mem_pkg::strb_t store_mask,
		logic [3:0] rd, logic reg_wen, mem_pkg::data_t exp_val);
		vector_t v;
		v.req.op         = op;
		v.req.width      = width;
		v.req.wb_src     = src;
		v.req.exu_val    = exu_val;
		v.req.csr_val    = csr_val;
		v.req.pc         = pc;
		v.req.store_data = store_data;
		v.req.store_mask = store_mask;
		v.req.rd         = rd;
		v.req.reg_wen    = reg_wen;
		v.exp_val        = exp_val;
		return v;
	endfunction

	// word at 0x40 is built up by byte and halfword stores, then read back in every width
	task automatic load_vectors();
		vectors[0]  = make_vector(lsu_pkg::op_alu, lsu_pkg::width_w, lsu_pkg::src_exu,
			32'h1234_5678, 32'h0, 32'h100, 32'h0, 4'h0, 4'd1, 1'b1, 32'h1234_5678);
		vectors[1]  = make_vector(lsu_pkg::op_alu, lsu_pkg::width_w, lsu_pkg::src_snpc,
			32'hdead_beef, 32'h0, 32'h204, 32'h0, 4'h0, 4'd2, 1'b1, 32'h0000_0208);
		vectors[2]  = make_vector(lsu_pkg::op_alu, lsu_pkg::width_w, lsu_pkg::src_csr,
			32'h0000_0011, 32'h8000_0001, 32'h300, 32'h0, 4'h0, 4'd3, 1'b0, 32'h8000_0001);
		vectors[3]  = make_vector(lsu_pkg::op_load, lsu_pkg::width_w, lsu_pkg::src_exu,
			32'h40, 32'h0, 32'h304, 32'h0, 4'h0, 4'd4, 1'b1, 32'h0);
		vectors[4]  = make_vector(lsu_pkg::op_store, lsu_pkg::width_w, lsu_pkg::src_exu,
			32'h40, 32'h0, 32'h308, 32'ha1b2_c3d4, 4'hf, 4'd0, 1'b0, 32'h40);
		vectors[5]  = make_vector(lsu_pkg::op_load, lsu_pkg::width_w, lsu_pkg::src_exu,
			32'h40, 32'h0, 32'h30c, 32'h0, 4'h0, 4'd5, 1'b1, 32'ha1b2_c3d4);
		vectors[6]  = make_vector(lsu_pkg::op_store, lsu_pkg::width_b, lsu_pkg::src_exu,
			32'h41, 32'h0, 32'h310, 32'h0000_0055, 4'h1, 4'd0, 1'b0, 32'h41);
		vectors[7]  = make_vector(lsu_pkg::op_store, lsu_pkg::width_b, lsu_pkg::src_exu,
			32'h43, 32'h0, 32'h314, 32'hffff_ff80, 4'h1, 4'd0, 1'b0, 32'h43);
		vectors[8]  = make_vector(lsu_pkg::op_load, lsu_pkg::width_w, lsu_pkg::src_exu,
			32'h40, 32'h0, 32'h318, 32'h0, 4'h0, 4'd6, 1'b1, 32'h80b2_55d4);
		vectors[9]  = make_vector(lsu_pkg::op_store, lsu_pkg::width_h, lsu_pkg::src_exu,
			32'h42, 32'h0, 32'h31c, 32'h0000_9abc, 4'h3, 4'd0, 1'b0, 32'h42);
		vectors[10] = make_vector(lsu_pkg::op_store, lsu_pkg::width_h, lsu_pkg::src_exu,
			32'h40, 32'h0, 32'h320, 32'h1234_8765, 4'h3, 4'd0, 1'b0, 32'h40);
		vectors[11] = make_vector(lsu_pkg::op_load, lsu_pkg::width_w, lsu_pkg::src_exu,
			32'h40, 32'h0, 32'h324, 32'h0, 4'h0, 4'd7, 1'b1, 32'h9abc_8765);
		vectors[12] = make_vector(lsu_pkg::op_load, lsu_pkg::width_b, lsu_pkg::src_exu,
			32'h43, 32'h0, 32'h328, 32'h0, 4'h0, 4'd8, 1'b1, 32'hffff_ff9a);
		vectors[13] = make_vector(lsu_pkg::op_load, lsu_pkg::width_bu, lsu_pkg::src_exu,
			32'h43, 32'h0, 32'h32c, 32'h0, 4'h0, 4'd9, 1'b1, 32'h0000_009a);
		vectors[14] = make_vector(lsu_pkg::op_load, lsu_pkg::width_h, lsu_pkg::src_exu,
			32'h42, 32'h0, 32'h330, 32'h0, 4'h0, 4'd10, 1'b1, 32'hffff_9abc);
		vectors[15] = make_vector(lsu_pkg::op_load, lsu_pkg::width_hu, lsu_pkg::src_exu,
			32'h42, 32'h0, 32'h334, 32'h0, 4'h0, 4'd11, 1'b1, 32'h0000_9abc);
		vectors[16] = make_vector(lsu_pkg::op_load, lsu_pkg::width_b, lsu_pkg::src_exu,
			32'h40, 32'h0, 32'h338, 32'h0, 4'h0, 4'd12, 1'b1, 32'h0000_0065);
		vectors[17] = make_vector(lsu_pkg::op_load, lsu_pkg::width_h, lsu_pkg::src_exu,
			32'h40, 32'h0, 32'h33c, 32'h0, 4'h0, 4'd13, 1'b1, 32'hffff_8765);
		vectors[18] = make_vector(lsu_pkg::op_store, lsu_pkg::width_b, lsu_pkg::src_exu,
			32'h82, 32'h0, 32'h340, 32'h0000_00c7, 4'h1, 4'd0, 1'b0, 32'h82);
		vectors[19] = make_vector(lsu_pkg::op_store, lsu_pkg::width_b, lsu_pkg::src_exu,
			32'h80, 32'h0, 32'h342, 32'h7766_555a, 4'h1, 4'd0, 1'b0, 32'h80);
		vectors[20] = make_vector(lsu_pkg::op_load, lsu_pkg::width_w, lsu_pkg::src_exu,
			32'h480, 32'h0, 32'h344, 32'h0, 4'h0, 4'd14, 1'b1, 32'h00c7_005a);
		vectors[21] = make_vector(lsu_pkg::op_store, lsu_pkg::width_w, lsu_pkg::src_exu,
			32'h4fc, 32'h0, 32'h348, 32'h0f1e_2d3c, 4'hf, 4'd0, 1'b0, 32'h4fc);
		vectors[22] = make_vector(lsu_pkg::op_load, lsu_pkg::width_w, lsu_pkg::src_exu,
			32'hfc, 32'h0, 32'h34c, 32'h0, 4'h0, 4'd1, 1'b1, 32'h0f1e_2d3c);
		vectors[23] = make_vector(lsu_pkg::op_load, lsu_pkg::width_w, lsu_pkg::src_exu,
			32'h3fc, 32'h0, 32'h350, 32'h0, 4'h0, 4'd2, 1'b1, 32'h0);
		vectors[24] = make_vector(lsu_pkg::op_alu, lsu_pkg::width_w, lsu_pkg::src_snpc,
			32'h0, 32'h0, 32'hffff_fffc, 32'h0, 4'h0, 4'd15, 1'b1, 32'h0);
	endtask

	function automatic void update_model(lsu_pkg::lsu_req_t q);
		int base;
		int off;
		base = int'(q.exu_val % mem_bytes);
		off  = base % 4;
		base = base - off;
		for (int i = 0; i < 4; i++) begin
			if (q.store_mask[i] && off + i < 4)
				model_mem[base + off + i] = q.store_data[8*i +: 8];
		end
	endfunction

	function automatic mem_pkg::data_t predict_wb(lsu_pkg::lsu_req_t q);
		int             base;
		int             off;
		mem_pkg::data_t lane;
		mem_pkg::data_t val;
		base = int'(q.exu_val % mem_bytes);
		off  = base % 4;
		base = base - off;
		lane = {model_mem[base + 3], model_mem[base + 2], model_mem[base + 1], model_mem[base]};
		lane = lane >> (8 * off);
		if (q.op == lsu_pkg::op_load) begin
			case (q.width)
				lsu_pkg::width_b:  val = 32'($signed(lane[7:0]));
				lsu_pkg::width_h:  val = 32'($signed(lane[15:0]));
				lsu_pkg::width_w:  val = lane;
				lsu_pkg::width_bu: val = 32'(lane[7:0]);
				lsu_pkg::width_hu: val = 32'(lane[15:0]);
				default:           val = '0;
			endcase
		end else begin
			case (q.wb_src)
				lsu_pkg::src_snpc: val = q.pc + 32'd4;
				lsu_pkg::src_csr:  val = q.csr_val;
				default:           val = q.exu_val;
			endcase
		end
		return val;
	endfunction

	task automatic check_value(input int idx, input string field,
		input mem_pkg::data_t got, input mem_pkg::data_t exp);
		assert (got === exp)
		else begin
			$display("error %0t: entry %0d %s is %h, expected %h", $time, idx, field, got, exp);
			errors++;
		end
	endtask

	task automatic run_entry(input int idx);
		lsu_pkg::lsu_req_t q;
		logic              hold;
		int                gap;
		int                errs_before;
		q           = vectors[idx].req;
		hold        = ($urandom_range(1, 0) == 1); // keep req_valid up while busy
		gap         = $urandom_range(3, 0);
		errs_before = errors;
		@(posedge clock);
		while (!req_ready)
			@(posedge clock);
		req       <= q;
		req_valid <= 1'b1;
		@(posedge clock); // accept edge
		if (!hold)
			req_valid <= 1'b0;
		@(posedge clock);
		while (!wb_valid)
			@(posedge clock);
		req_valid <= 1'b0;
		@(negedge clock);
		if (q.op == lsu_pkg::op_store)
			update_model(q);
		check_value(idx, "wb_val (table)", wb.wb_val, vectors[idx].exp_val);
		check_value(idx, "wb_val (model)", wb.wb_val, predict_wb(q));
		check_value(idx, "rd", 32'(wb.rd), 32'(q.rd));
		check_value(idx, "reg_wen", 32'(wb.reg_wen), 32'(q.reg_wen));
		check_value(idx, "pc", wb.pc, q.pc);
		check_value(idx, "accept count", accept_count, idx + 1);
		check_value(idx, "write-back count", wb_count, idx + 1);
		if (errors == errs_before)
			$display("entry %0d ok: wb_val %h rd %0d", idx, wb.wb_val, wb.rd);
		repeat (gap) @(posedge clock);
	endtask

	// request and write-back handshake monitor
	always @(posedge clock) begin
		if (!reset) begin
			if (busy) begin
				assert (!req_ready)
				else begin
					$display("error %0t: req_ready high before the write-back", $time);
					errors++;
				end
			end
			if (wb_valid) begin
				assert (busy)
				else begin
					$display("error %0t: wb_valid without an accepted request", $time);
					errors++;
				end
				busy = 1'b0;
				wb_count++;
			end
			if (req_valid && req_ready) begin
				busy = 1'b1;
				accept_count++;
			end
		end
	end

	initial begin
		repeat (timeout_cycles) @(posedge clock);
		$display("watchdog expired after %0d cycles, the write-back never arrived",
			timeout_cycles);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		void'($urandom(61));
		reset     = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		for (int i = 0; i < mem_bytes; i++)
			model_mem[i] = 8'h00;
		load_vectors();
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		assert (req_ready && !wb_valid && !i_dut.ar_valid && !i_dut.aw_valid
			&& !i_dut.w_valid && !i_dut.r_valid && !i_dut.b_valid)
		else begin
			$display("error %0t: handshake outputs not idle after reset", $time);
			errors++;
		end
		for (int i = 0; i < num_entries; i++)
			run_entry(i);
		repeat (4) @(posedge clock);
		@(negedge clock);
		check_value(num_entries, "final accept count", accept_count, num_entries);
		check_value(num_entries, "final write-back count", wb_count, num_entries);
		$display("%0d entries, %0d accepts, %0d write-backs, %0d errors",
			num_entries, accept_count, wb_count, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
